/* list.f */
verilog/rv_pkg.sv
verilog/uart_rx.sv
verilog/imem_loader.sv
verilog/rv_decode.sv
verilog/reg_file.sv
verilog/rv_core.sv
verilog/riscv_core_uart.sv
sim/tb_riscv_core_uart_sva.sv
sim/tb_riscv_core_uart.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the riscv_core_uart testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_riscv_core_uart -f list.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# keep running after an assertion so the bench can print its summary
out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* sim/tb_riscv_core_uart.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_riscv_core_uart;
    import rv_pkg::*;

    // uart load of both programs plus run and reads, doubled
    localparam int    TIMEOUT_CYCLES = 20000;
    localparam int    LOOP_N         = 7;
    localparam word_t LOOP_SUM       = 32'(LOOP_N * (LOOP_N + 1) / 2);

    logic        clk;
    logic        rst;
    logic        prog;
    logic        rx;
    logic        debug;
    reg_idx_t    debug_input;
    word_t       debug_output;

    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    word_t       image[$];
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    word_t       a_val;
    word_t       b_val;
    word_t       c_val;

    riscv_core_uart u_dut (
        .clk          (clk),
        .rst          (rst),
        .prog         (prog),
        .rx           (rx),
        .debug        (debug),
        .debug_input  (debug_input),
        .debug_output (debug_output)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // instruction encoders, straight from the rv32i formats
    //////////////////////////////////////////////////////////////////////

    function automatic word_t sign_extend(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t addi_word(input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_idx_t rd, input reg_idx_t rs1,
                                         input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // byte offset, bit 0 dropped
    function automatic word_t branch_word(input logic [2:0] f3, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drivers and checks
    //////////////////////////////////////////////////////////////////////

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // 8N1, lsb first, then wait for the byte strobe
    task automatic send_byte(input logic [7:0] b);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) next_cycle();
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (CLKS_PER_BIT) next_cycle();
        end
        rx = 1'b1;
        while (!u_dut.rx_valid) begin
            next_cycle();
        end
        // rest of the stop bit
        repeat (CLKS_PER_BIT / 2) next_cycle();
    endtask

    // little endian
    task automatic send_word(input word_t w);
        send_byte(w[7:0]);
        send_byte(w[15:8]);
        send_byte(w[23:16]);
        send_byte(w[31:24]);
    endtask

    task automatic send_image();
        foreach (image[i]) begin
            send_word(image[i]);
        end
    endtask

    // halt is a branch to itself, so pc stops moving
    task automatic wait_for_halt();
        word_t prev;
        prev = u_dut.u_core.pc_q;
        next_cycle();
        while (u_dut.u_core.pc_q != prev) begin
            prev = u_dut.u_core.pc_q;
            next_cycle();
        end
    endtask

    // debug read, output is registered
    task automatic check_reg(input string name, input reg_idx_t idx, input word_t exp);
        debug       = 1'b1;
        debug_input = idx;
        next_cycle();
        next_cycle();
        checks++;
        assert (debug_output == exp) else begin
            errors++;
            $display("Error: %s x%0d expected %h actual %h", name, idx, exp, debug_output);
        end
    endtask

    task automatic check_blank(input string name);
        debug = 1'b0;
        next_cycle();
        checks++;
        assert (debug_output == '0) else begin
            errors++;
            $display("Error: %s expected %h actual %h", name, 32'h0, debug_output);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        prog        = 1'b0;
        rx          = 1'b1;
        debug       = 1'b0;
        debug_input = '0;
        void'($urandom(32'h68b1));
        repeat (3) next_cycle();
        rst = 1'b0;

        // empty register file
        check_blank("idle_debug");
        check_reg("reset_x1", 5'd1, 32'h0);
        check_reg("reset_x31", 5'd31, 32'h0);
        check_blank("debug_low");

        // distinct operands so the first beq falls through
        imm_a = 12'($urandom());
        imm_b = 12'($urandom());
        if (imm_b == imm_a) begin
            imm_b = imm_a ^ 12'h001;
        end
        a_val = sign_extend(imm_a);
        b_val = sign_extend(imm_b);

        // program a, alu ops, x0 write, loop and branches
        image.delete();
        image.push_back(addi_word(5'd1, 5'd0, imm_a));
        image.push_back(addi_word(5'd2, 5'd0, imm_b));
        image.push_back(rtype_word(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
        image.push_back(rtype_word(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2));
        image.push_back(rtype_word(7'b0000000, 3'b111, 5'd7, 5'd1, 5'd2));
        image.push_back(rtype_word(7'b0000000, 3'b110, 5'd8, 5'd1, 5'd2));
        image.push_back(rtype_word(7'b0000000, 3'b100, 5'd9, 5'd1, 5'd2));
        image.push_back(addi_word(5'd0, 5'd1, 12'd5));
        image.push_back(addi_word(5'd5, 5'd0, 12'(LOOP_N)));
        image.push_back(addi_word(5'd6, 5'd0, 12'd0));
        // loop body at word 10
        image.push_back(rtype_word(7'b0000000, 3'b000, 5'd6, 5'd6, 5'd5));
        image.push_back(addi_word(5'd5, 5'd5, 12'hfff));
        image.push_back(branch_word(3'b001, 5'd5, 5'd0, 13'(-8)));
        // unequal beq, falls through
        image.push_back(branch_word(3'b000, 5'd1, 5'd2, 13'd8));
        image.push_back(addi_word(5'd10, 5'd0, 12'd77));
        // equal beq skips the next addi
        image.push_back(branch_word(3'b000, 5'd0, 5'd0, 13'd8));
        image.push_back(addi_word(5'd11, 5'd0, 12'd99));
        image.push_back(branch_word(3'b000, 5'd0, 5'd0, 13'd0));

        prog = 1'b1;
        next_cycle();
        send_image();
        prog = 1'b0;
        wait_for_halt();

        check_reg("addi_a", 5'd1, a_val);
        check_reg("addi_b", 5'd2, b_val);
        check_reg("add", 5'd3, a_val + b_val);
        check_reg("sub", 5'd4, a_val - b_val);
        check_reg("and", 5'd7, a_val & b_val);
        check_reg("or", 5'd8, a_val | b_val);
        check_reg("xor", 5'd9, a_val ^ b_val);
        check_reg("addi_x0", 5'd0, 32'h0);
        check_reg("loop_count", 5'd5, 32'h0);
        check_reg("loop_sum", 5'd6, LOOP_SUM);
        check_reg("beq_fall", 5'd10, 32'd77);
        check_reg("beq_skip", 5'd11, 32'h0);
        check_blank("debug_low_a");

        imm_c = 12'($urandom());
        if (imm_c == imm_a) begin
            imm_c = ~imm_a;
        end
        c_val = sign_extend(imm_c);

        // program b, must land at word 0 again
        image.delete();
        image.push_back(addi_word(5'd1, 5'd0, imm_c));
        image.push_back(addi_word(5'd3, 5'd0, 12'd55));
        image.push_back(rtype_word(7'b0100000, 3'b000, 5'd9, 5'd0, 5'd1));
        image.push_back(branch_word(3'b000, 5'd0, 5'd0, 13'd0));

        prog = 1'b1;
        next_cycle();
        // registers untouched during the load
        check_reg("hold_x3", 5'd3, a_val + b_val);
        check_reg("hold_x6", 5'd6, LOOP_SUM);
        send_image();
        check_reg("hold_x1", 5'd1, a_val);
        check_reg("hold_x9", 5'd9, a_val ^ b_val);
        debug = 1'b0;
        prog  = 1'b0;
        wait_for_halt();

        check_reg("reload_x1", 5'd1, c_val);
        check_reg("reload_x3", 5'd3, 32'd55);
        check_reg("reload_x9", 5'd9, 32'h0 - c_val);
        check_reg("keep_x6", 5'd6, LOOP_SUM);
        check_reg("keep_x10", 5'd10, 32'd77);
        check_blank("debug_low_b");

        $display("checks %0d, check errors %0d, assertion errors %0d",
                 checks, errors, u_dut.u_sva.fail_count);
        if (errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_riscv_core_uart_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_riscv_core_uart_sva (
    input logic               clk,
    input logic               rst,
    input logic               prog,
    input logic               debug,
    input rv_pkg::word_t      debug_output,
    input logic               rx_valid,
    input logic               wb_we,
    input rv_pkg::imem_addr_t fetch_addr
);

    // number of failed assertions, read by the bench summary
    int fail_count = 0;

    // debug port blanks one clock after debug drops
    debug_blank: assert property (@(posedge clk) !debug |=> debug_output == '0)
        else begin
            $error("debug_output not zero one cycle after debug low");
            fail_count++;
        end

    // nothing retires while loading
    no_wb_in_prog: assert property (@(posedge clk) disable iff (rst) prog |-> !wb_we)
        else begin
            $error("register write while prog high");
            fail_count++;
        end

    // pc word index pinned at 0 during prog
    pc_held: assert property (@(posedge clk) disable iff (rst) prog |-> fetch_addr == '0)
        else begin
            $error("pc not zero while prog high");
            fail_count++;
        end

    // byte strobe is a single clock
    strobe_width: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
        else begin
            $error("rx_valid high two cycles in a row");
            fail_count++;
        end

endmodule

bind riscv_core_uart tb_riscv_core_uart_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .prog         (prog),
    .debug        (debug),
    .debug_output (debug_output),
    .rx_valid     (rx_valid),
    .wb_we        (wb_we),
    .fetch_addr   (fetch_addr)
);

`default_nettype wire

/* verilog/imem_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module imem_loader (
    input  logic               clk,
    input  logic               rst,
    input  logic               prog,
    input  logic [7:0]         rx_data,
    input  logic               rx_valid,
    input  rv_pkg::imem_addr_t fetch_addr,
    output rv_pkg::word_t      fetch_instr
);
    import rv_pkg::*;

    word_t      mem [IMEM_DEPTH];
    word_t      shift_q;
    word_t      wr_word;
    logic [1:0] byte_cnt;
    imem_addr_t wr_addr;
    logic       prog_q;
    logic       prog_rise;
    logic       load_en;

    // new load starts at word 0
    assign prog_rise = prog & ~prog_q;
    // bytes outside prog are ignored
    assign load_en   = rx_valid & prog & ~prog_rise;
    // little endian, first byte lands in [7:0]
    assign wr_word   = {rx_data, shift_q[31:8]};

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_q <= 1'b0;
        end else begin
            prog_q <= prog;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // byte packing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || prog_rise) begin
            byte_cnt <= '0;
            wr_addr  <= '0;
        end else if (load_en) begin
            byte_cnt <= byte_cnt + 1'b1;
            // step to next word after the fourth byte
            if (byte_cnt == 2'd3) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            shift_q <= wr_word;
        end
    end

    // memory, zero after rst so empty words decode as no-ops
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (load_en && byte_cnt == 2'd3) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // async fetch read
    assign fetch_instr = mem[fetch_addr];

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wb_we,
    input  rv_pkg::reg_idx_t wb_idx,
    input  rv_pkg::word_t    wb_data,
    input  logic             debug,
    input  rv_pkg::reg_idx_t debug_input,
    output rv_pkg::word_t    debug_output
);
    import rv_pkg::*;

    word_t regs [NUM_REGS];

    // x0 reads as zero on every port
    function automatic word_t read_reg(input reg_idx_t idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    // write on the edge, x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    assign rs1_data = read_reg(rs1_idx);
    assign rs2_data = read_reg(rs2_idx);

    //////////////////////////////////////////////////////////////////////
    // debug read port
    //////////////////////////////////////////////////////////////////////

    // registered, zero when debug is low
    always_ff @(posedge clk) begin
        if (rst || !debug) begin
            debug_output <= '0;
        end else begin
            debug_output <= read_reg(debug_input);
        end
    end

endmodule

`default_nettype wire

/* verilog/riscv_core_uart.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv_core_uart (
    input  logic             clk,
    input  logic             rst,
    input  logic             prog,
    input  logic             rx,
    input  logic             debug,
    input  rv_pkg::reg_idx_t debug_input,
    output rv_pkg::word_t    debug_output
);
    import rv_pkg::*;

    logic [7:0] rx_data;
    logic       rx_valid;
    imem_addr_t fetch_addr;
    word_t      fetch_instr;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       wb_we;
    reg_idx_t   wb_idx;
    word_t      wb_data;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    // program store, loaded over uart
    imem_loader u_imem_loader (
        .clk         (clk),
        .rst         (rst),
        .prog        (prog),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr)
    );

    //////////////////////////////////////////////////////////////////////
    // core and register file
    //////////////////////////////////////////////////////////////////////

    rv_core u_core (
        .clk         (clk),
        .rst         (rst),
        .prog        (prog),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_we       (wb_we),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data)
    );

    // debug port lives here
    reg_file u_reg_file (
        .clk          (clk),
        .rst          (rst),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_we        (wb_we),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .debug        (debug),
        .debug_input  (debug_input),
        .debug_output (debug_output)
    );

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               prog,
    output rv_pkg::imem_addr_t fetch_addr,
    input  rv_pkg::word_t      fetch_instr,
    output rv_pkg::reg_idx_t   rs1_idx,
    output rv_pkg::reg_idx_t   rs2_idx,
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      rs2_data,
    output logic               wb_we,
    output rv_pkg::reg_idx_t   wb_idx,
    output rv_pkg::word_t      wb_data
);
    import rv_pkg::*;

    word_t    pc_q;
    word_t    pc;
    word_t    next_pc;
    word_t    op_b;
    word_t    alu_res;
    decoded_t dec;
    logic     rs_equal;
    logic     br_taken;

    //////////////////////////////////////////////////////////////////////
    // fetch and decode
    //////////////////////////////////////////////////////////////////////

    // pc reads as 0 for the whole prog window
    assign pc         = prog ? '0 : pc_q;
    // byte pc, word index into imem
    assign fetch_addr = pc[IMEM_AW+1:2];

    rv_decode u_decode (
        .instr (fetch_instr),
        .dec   (dec)
    );

    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    //////////////////////////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////////////////////////

    assign op_b = dec.use_imm ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu)
            ALU_ADD:   alu_res = rs1_data + op_b;
            ALU_SUB:   alu_res = rs1_data - op_b;
            ALU_AND:   alu_res = rs1_data & op_b;
            ALU_OR:    alu_res = rs1_data | op_b;
            ALU_XOR:   alu_res = rs1_data ^ op_b;
            ALU_PASS0: alu_res = '0;
            default:   alu_res = '0;
        endcase
    end

    // beq and bne compare
    assign rs_equal = (rs1_data == rs2_data);
    assign br_taken = dec.is_branch & (dec.br_ne ? ~rs_equal : rs_equal);
    assign next_pc  = br_taken ? pc + dec.imm : pc + 32'd4;

    // one instruction per clock
    always_ff @(posedge clk) begin
        if (rst || prog) begin
            pc_q <= '0;
        end else begin
            pc_q <= next_pc;
        end
    end

    // writeback on the same edge
    // nothing retires while loading
    assign wb_we   = dec.reg_we & ~prog;
    assign wb_idx  = dec.rd;
    assign wb_data = alu_res;

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  rv_pkg::word_t    instr,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    //////////////////////////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // default is a no-op
        dec           = '0;
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.rd        = instr[11:7];
        dec.alu       = ALU_PASS0;
        case (opcode)
            OPC_OP_IMM: begin
                // only addi
                if (funct3 == F3_ADD_SUB) begin
                    dec.imm     = imm_i;
                    dec.alu     = ALU_ADD;
                    dec.use_imm = 1'b1;
                    dec.reg_we  = 1'b1;
                end
            end
            OPC_OP: begin
                dec.reg_we = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: dec.alu = ALU_ADD;
                    {F7_ALT, F3_ADD_SUB}:  dec.alu = ALU_SUB;
                    {F7_BASE, F3_AND}:     dec.alu = ALU_AND;
                    {F7_BASE, F3_OR}:      dec.alu = ALU_OR;
                    {F7_BASE, F3_XOR}:     dec.alu = ALU_XOR;
                    default:               dec.reg_we = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                // beq and bne only, no writeback
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    dec.imm       = imm_b;
                    dec.is_branch = 1'b1;
                    dec.br_ne     = (funct3 == F3_BNE);
                end
            end
            default: begin
                dec.reg_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////////////////////////

    // data and instruction word
    typedef logic [31:0] word_t;
    // architectural register index
    typedef logic [4:0] reg_idx_t;

    localparam int NUM_REGS   = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    // word address into instruction memory
    typedef logic [IMEM_AW-1:0] imem_addr_t;

    // clocks per uart bit, sampled mid-bit
    localparam int CLKS_PER_BIT = 8;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 for plain ops and for sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS0
    } alu_op_t;

    // control bundle from decode to execute
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        alu_op_t  alu;
        logic     use_imm;
        logic     reg_we;
        logic     is_branch;
        logic     br_ne;
    } decoded_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    import rv_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic             rx_meta;
    logic             rx_sync;
    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_q;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // receive fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // strobe lasts one clock
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // recheck at mid start bit, glitch goes back to idle
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    // low stop bit drops the byte
                    if (clk_cnt == FULL_BIT) begin
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first, shift in at mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == FULL_BIT) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign rx_data = shift_q;

endmodule

`default_nettype wire
